// ==== verilog/dhcp_pkg.sv ====
package dhcp_pkg;

    // Buffer geometry
    localparam int BUF_ADDR_W = 9;                 // 512 bytes
    localparam int BUF_BANK_W = 2;                 // Four host banks of 128 bytes

    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
    typedef logic [7:0]            byte_t;
    typedef logic [31:0]           ip_addr_t;
    typedef logic [47:0]           mac_addr_t;

    // Receive side offsets
    localparam buf_addr_t PARTIAL_THRESHOLD = 9'd8;  // Enough bytes to check the XID
    localparam buf_addr_t XID_OFFSET        = 9'd4;  // XID occupies bytes 4 to 7

    // Transmit destination, always broadcast to the server port
    localparam logic [15:0] DHCP_SERVER_PORT = 16'd67;
    localparam ip_addr_t    BROADCAST_IP     = 32'hFFFF_FFFF;

    // Bits of a control register write
    localparam int CTRL_ACCEPT_BIT    = 0;         // Arm for next packet
    localparam int CTRL_TRANSMIT_BIT  = 4;         // Send buffer contents
    localparam int CTRL_IP_TOGGLE_BIT = 7;         // Flip IP valid

    // Host register map, port_id bits 4:0
    typedef enum logic [4:0] {
        REG_CONTROL   = 5'd0,
        REG_BANK      = 5'd1,
        REG_TX_LEN_LO = 5'd2,
        REG_TX_LEN_HI = 5'd3,
        REG_IP0       = 5'd4,
        REG_IP1       = 5'd5,
        REG_IP2       = 5'd6,
        REG_IP3       = 5'd7,
        REG_MAC0      = 5'd8,
        REG_MAC1      = 5'd9,
        REG_MAC2      = 5'd10,
        REG_MAC3      = 5'd11,
        REG_MAC4      = 5'd12,
        REG_MAC5      = 5'd13,
        REG_XID0      = 5'd16,
        REG_XID1      = 5'd17,
        REG_XID2      = 5'd18,
        REG_XID3      = 5'd19
    } reg_addr_e;

    // UDP core's answer to a transmit start
    typedef enum logic [1:0] {
        TX_RESULT_NONE     = 2'd0,
        TX_RESULT_ACCEPTED = 2'd1
    } tx_result_e;

    typedef struct packed {
        logic  write_strobe;
        byte_t port_id;                            // Bit 7 selects the buffer
        byte_t data;
    } host_bus_t;

    typedef struct packed {
        logic  start;
        byte_t data;
        logic  valid;
        logic  last;
    } udp_rx_t;

    typedef struct packed {
        logic        start;
        byte_t       data;
        logic        valid;
        logic        last;
        buf_addr_t   length;
        ip_addr_t    dst_ip;
        logic [15:0] dst_port;
    } udp_tx_t;

    typedef struct packed {
        logic     accepting;
        logic     partial_done;
        ip_addr_t xid;                             // Byte 4 of the packet in bits 7:0
    } rx_status_t;

endpackage

// ==== verilog/udp_rx_capture.sv ====
`timescale 1ns/10ps

module udp_rx_capture (
    input  logic                  clk,
    input  logic                  reset,
    input  dhcp_pkg::udp_rx_t     rx_in,
    input  logic                  accept_cmd,
    input  logic                  transmitting,
    output dhcp_pkg::rx_status_t  rx_status,
    output dhcp_pkg::buf_addr_t   rx_addr,
    output logic                  rx_write,
    output logic                  rx_active,
    output logic                  armed
);

    logic                start_q;          // Start from last cycle, for edge detect
    logic                start_edge;
    logic                going_to_accept;  // First cycle of a captured packet
    logic                accepting;
    logic                partial_done;
    dhcp_pkg::ip_addr_t  xid;
    dhcp_pkg::buf_addr_t xid_idx;
    logic                xid_byte;

    assign start_edge      = rx_in.start && !start_q;
    assign going_to_accept = armed && start_edge && !transmitting;
    assign rx_active       = going_to_accept || accepting;
    assign rx_write        = rx_active && rx_in.valid;   // Byte 0 lands in the start cycle

    // Offset into the XID field, only meaningful inside bytes 4 to 7
    assign xid_idx  = rx_addr - dhcp_pkg::XID_OFFSET;
    assign xid_byte = (rx_addr >= dhcp_pkg::XID_OFFSET) &&
                      (rx_addr < dhcp_pkg::XID_OFFSET + 9'd4);

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q      <= 1'b0;
            armed        <= 1'b0;
            accepting    <= 1'b0;
            partial_done <= 1'b0;
            rx_addr      <= '0;
            xid          <= '0;
        end else begin
            start_q <= rx_in.start;

            // Armed by the host, spent at the next packet start
            if (accept_cmd)
                armed <= 1'b1;
            else if (start_edge && !transmitting)
                armed <= 1'b0;

            // A one-byte packet is written but never enters accepting
            if (going_to_accept && !rx_in.last)
                accepting <= 1'b1;
            else if (accepting && rx_in.last && rx_in.valid)
                accepting <= 1'b0;

            // Partial flag lets the host look at the XID mid-packet
            if (!accepting || armed)
                partial_done <= 1'b0;
            else if (rx_addr == dhcp_pkg::PARTIAL_THRESHOLD && rx_in.valid)
                partial_done <= 1'b1;

            if (!rx_active)
                rx_addr <= '0;                            // Parked at 0 between packets
            else if (rx_in.valid)
                rx_addr <= rx_addr + 9'd1;

            if (rx_write && xid_byte)
                xid[xid_idx[1:0]*8 +: 8] <= rx_in.data;   // Byte 4 into bits 7:0
        end
    end

    always_comb begin
        rx_status.accepting    = accepting;
        rx_status.partial_done = partial_done;
        rx_status.xid          = xid;
    end

endmodule

// ==== verilog/packet_buffer.sv ====
`timescale 1ns/10ps

module packet_buffer (
    input  logic                               clk,
    input  dhcp_pkg::host_bus_t                host,
    input  logic [dhcp_pkg::BUF_BANK_W-1:0]    bank,
    input  logic                               rx_active,
    input  dhcp_pkg::buf_addr_t                rx_addr,
    input  logic                               rx_write,
    input  dhcp_pkg::byte_t                    rx_data,
    input  logic                               transmitting,
    input  dhcp_pkg::buf_addr_t                tx_addr,
    output dhcp_pkg::byte_t                    rd_data
);

    localparam int DEPTH = 1 << dhcp_pkg::BUF_ADDR_W;

    dhcp_pkg::byte_t     mem [DEPTH];
    dhcp_pkg::buf_addr_t addr;
    dhcp_pkg::buf_addr_t host_addr;
    logic                host_write;
    logic                wr_en;
    dhcp_pkg::byte_t     wr_data;

    // Host sees a 128-byte window selected by the bank register
    assign host_addr = {bank, host.port_id[6:0]};

    // Receive has priority, then transmit, then the host
    always_comb begin
        if (rx_active)
            addr = rx_addr;
        else if (transmitting)
            addr = tx_addr;
        else
            addr = host_addr;
    end

    // Host writes are dropped while either stream owns the buffer
    assign host_write = host.write_strobe && host.port_id[7] && !rx_active && !transmitting;
    assign wr_en      = rx_write || host_write;
    assign wr_data    = rx_active ? rx_data : host.data;

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[addr] <= wr_data;
        rd_data <= mem[addr];      // Read before write with one cycle latency
    end

    // Receive writes only come while receive owns the address and data mux
    a_rx_write_owned : assert property (@(posedge clk) rx_write |-> rx_active)
        else $error("Receive write while the receive side does not own the buffer");

endmodule

// ==== verilog/host_regs.sv ====
`timescale 1ns/10ps

module host_regs (
    input  logic                               clk,
    input  logic                               reset,
    input  dhcp_pkg::host_bus_t                host,
    input  dhcp_pkg::mac_addr_t                mac_address,
    input  logic                               do_dhcp,
    input  dhcp_pkg::rx_status_t               rx_status,
    input  logic                               armed,
    input  logic                               transmitting,
    input  dhcp_pkg::byte_t                    buf_rd_data,
    output logic                               accept_cmd,
    output logic                               transmit_cmd,
    output dhcp_pkg::buf_addr_t                tx_length,
    output logic [dhcp_pkg::BUF_BANK_W-1:0]    bank,
    output dhcp_pkg::ip_addr_t                 ip_address,
    output logic                               ip_address_valid,
    output dhcp_pkg::byte_t                    rd_data
);

    logic            reg_write;
    logic [4:0]      reg_sel;
    logic            control_write;
    logic            dhcp_seen;       // Sticky until reset
    dhcp_pkg::byte_t status;
    dhcp_pkg::byte_t reg_mux;
    dhcp_pkg::byte_t reg_rd_q;
    logic            buf_sel_q;       // Previous access went to the buffer

    assign reg_write     = host.write_strobe && !host.port_id[7];
    assign reg_sel       = host.port_id[4:0];    // Bits 6:5 are ignored
    assign control_write = reg_write && (reg_sel == dhcp_pkg::REG_CONTROL);

    // Command pulses last as long as the strobe
    assign accept_cmd   = control_write && host.data[dhcp_pkg::CTRL_ACCEPT_BIT];
    assign transmit_cmd = control_write && host.data[dhcp_pkg::CTRL_TRANSMIT_BIT];

    assign status = {ip_address_valid, dhcp_seen, 1'b0, transmitting,
                     1'b0, rx_status.partial_done, rx_status.accepting, armed};

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_length        <= '0;
            bank             <= '0;
            ip_address       <= '0;
            ip_address_valid <= 1'b0;
            dhcp_seen        <= 1'b0;
        end else begin
            if (do_dhcp)
                dhcp_seen <= 1'b1;

            if (control_write && host.data[dhcp_pkg::CTRL_IP_TOGGLE_BIT])
                ip_address_valid <= ~ip_address_valid;

            if (reg_write) begin
                case (reg_sel)
                    dhcp_pkg::REG_BANK:      bank           <= host.data[dhcp_pkg::BUF_BANK_W-1:0];
                    dhcp_pkg::REG_TX_LEN_LO: tx_length[7:0] <= host.data;
                    dhcp_pkg::REG_TX_LEN_HI: tx_length[8]   <= host.data[0];   // Only bit 0 kept
                    dhcp_pkg::REG_IP0:       ip_address[7:0]   <= host.data;
                    dhcp_pkg::REG_IP1:       ip_address[15:8]  <= host.data;
                    dhcp_pkg::REG_IP2:       ip_address[23:16] <= host.data;
                    dhcp_pkg::REG_IP3:       ip_address[31:24] <= host.data;
                    default: ;                               // Control handled above, rest read-only
                endcase
            end
        end
    end

    // Register read mux, MAC is big-endian
    always_comb begin
        case (reg_sel)
            dhcp_pkg::REG_CONTROL:   reg_mux = status;
            dhcp_pkg::REG_BANK:      reg_mux = {{(8-dhcp_pkg::BUF_BANK_W){1'b0}}, bank};
            dhcp_pkg::REG_TX_LEN_LO: reg_mux = tx_length[7:0];
            dhcp_pkg::REG_TX_LEN_HI: reg_mux = {7'd0, tx_length[8]};
            dhcp_pkg::REG_IP0:       reg_mux = ip_address[7:0];
            dhcp_pkg::REG_IP1:       reg_mux = ip_address[15:8];
            dhcp_pkg::REG_IP2:       reg_mux = ip_address[23:16];
            dhcp_pkg::REG_IP3:       reg_mux = ip_address[31:24];
            dhcp_pkg::REG_MAC0:      reg_mux = mac_address[47:40];
            dhcp_pkg::REG_MAC1:      reg_mux = mac_address[39:32];
            dhcp_pkg::REG_MAC2:      reg_mux = mac_address[31:24];
            dhcp_pkg::REG_MAC3:      reg_mux = mac_address[23:16];
            dhcp_pkg::REG_MAC4:      reg_mux = mac_address[15:8];
            dhcp_pkg::REG_MAC5:      reg_mux = mac_address[7:0];
            dhcp_pkg::REG_XID0:      reg_mux = rx_status.xid[7:0];
            dhcp_pkg::REG_XID1:      reg_mux = rx_status.xid[15:8];
            dhcp_pkg::REG_XID2:      reg_mux = rx_status.xid[23:16];
            dhcp_pkg::REG_XID3:      reg_mux = rx_status.xid[31:24];
            default:                 reg_mux = 8'h00;    // Unmapped
        endcase
    end

    // Registers line up with the buffer's synchronous read
    always_ff @(posedge clk) begin
        reg_rd_q  <= reg_mux;
        buf_sel_q <= host.port_id[7];
    end

    assign rd_data = buf_sel_q ? buf_rd_data : reg_rd_q;

endmodule

// ==== verilog/udp_tx_stream.sv ====
`timescale 1ns/10ps

module udp_tx_stream (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  transmit_cmd,
    input  dhcp_pkg::buf_addr_t   tx_length,     // Bytes to send minus 1
    input  dhcp_pkg::tx_result_e  tx_result,
    input  logic                  ready,
    input  dhcp_pkg::byte_t       buf_rd_data,
    output dhcp_pkg::udp_tx_t     tx_out,
    output dhcp_pkg::buf_addr_t   tx_addr,
    output logic                  transmitting
);

    logic start_req;   // Held until the UDP core accepts
    logic valid;
    logic accepted;    // Byte taken this cycle
    logic last_byte;

    assign accepted  = transmitting && valid && ready;
    assign last_byte = transmitting && (tx_addr == tx_length);

    always_ff @(posedge clk) begin
        if (reset) begin
            start_req    <= 1'b0;
            transmitting <= 1'b0;
            valid        <= 1'b0;
            tx_addr      <= '0;
        end else begin
            if (transmit_cmd)
                start_req <= 1'b1;
            else if (start_req && tx_result == dhcp_pkg::TX_RESULT_ACCEPTED)
                start_req <= 1'b0;

            if (transmit_cmd)
                transmitting <= 1'b1;
            else if (accepted && last_byte)
                transmitting <= 1'b0;   // Done after the final byte moves

            // Valid waits a cycle for the buffer read, drops after every accept
            if (!transmitting)
                valid <= 1'b0;
            else if (!valid)
                valid <= 1'b1;
            else if (ready)
                valid <= 1'b0;

            if (!transmitting)
                tx_addr <= '0;
            else if (accepted)
                tx_addr <= tx_addr + 9'd1;
        end
    end

    always_comb begin
        tx_out.start    = start_req;
        tx_out.data     = buf_rd_data;               // Holds with tx_addr under back-pressure
        tx_out.valid    = valid;
        tx_out.last     = last_byte;
        tx_out.length   = tx_length + 9'd1;
        tx_out.dst_ip   = dhcp_pkg::BROADCAST_IP;
        tx_out.dst_port = dhcp_pkg::DHCP_SERVER_PORT;
    end

    a_valid_in_frame : assert property (@(posedge clk) disable iff (reset)
                                        tx_out.valid |-> transmitting)
        else $error("Transmit valid outside a packet");

endmodule

// ==== verilog/dhcp_top.sv ====
`timescale 1ns/10ps

module dhcp_top (
    input  logic                  clk,
    input  logic                  reset,
    input  dhcp_pkg::udp_rx_t     udp_in,
    input  logic                  udp_out_ready,
    input  dhcp_pkg::tx_result_e  udp_out_result,
    output dhcp_pkg::udp_tx_t     udp_out,
    input  dhcp_pkg::host_bus_t   host,
    output dhcp_pkg::byte_t       host_rd_data,
    input  dhcp_pkg::mac_addr_t   mac_address,
    input  logic                  do_dhcp,
    output dhcp_pkg::ip_addr_t    ip_address,
    output logic                  ip_address_valid
);

    logic                              accept_cmd;
    logic                              transmit_cmd;
    dhcp_pkg::buf_addr_t               tx_length;
    logic [dhcp_pkg::BUF_BANK_W-1:0]   bank;
    dhcp_pkg::rx_status_t              rx_status;
    dhcp_pkg::buf_addr_t               rx_addr;
    logic                              rx_write;
    logic                              rx_active;
    logic                              armed;
    dhcp_pkg::buf_addr_t               tx_addr;
    logic                              transmitting;
    dhcp_pkg::byte_t                   buf_rd_data;   // Shared by host reads and transmit

    udp_rx_capture rx_capture_inst (
        .clk          (clk),
        .reset        (reset),
        .rx_in        (udp_in),
        .accept_cmd   (accept_cmd),
        .transmitting (transmitting),
        .rx_status    (rx_status),
        .rx_addr      (rx_addr),
        .rx_write     (rx_write),
        .rx_active    (rx_active),
        .armed        (armed)
    );

    packet_buffer packet_buffer_inst (
        .clk          (clk),
        .host         (host),
        .bank         (bank),
        .rx_active    (rx_active),
        .rx_addr      (rx_addr),
        .rx_write     (rx_write),
        .rx_data      (udp_in.data),
        .transmitting (transmitting),
        .tx_addr      (tx_addr),
        .rd_data      (buf_rd_data)
    );

    host_regs host_regs_inst (
        .clk              (clk),
        .reset            (reset),
        .host             (host),
        .mac_address      (mac_address),
        .do_dhcp          (do_dhcp),
        .rx_status        (rx_status),
        .armed            (armed),
        .transmitting     (transmitting),
        .buf_rd_data      (buf_rd_data),
        .accept_cmd       (accept_cmd),
        .transmit_cmd     (transmit_cmd),
        .tx_length        (tx_length),
        .bank             (bank),
        .ip_address       (ip_address),
        .ip_address_valid (ip_address_valid),
        .rd_data          (host_rd_data)
    );

    udp_tx_stream tx_stream_inst (
        .clk          (clk),
        .reset        (reset),
        .transmit_cmd (transmit_cmd),
        .tx_length    (tx_length),
        .tx_result    (udp_out_result),
        .ready        (udp_out_ready),
        .buf_rd_data  (buf_rd_data),
        .tx_out       (udp_out),
        .tx_addr      (tx_addr),
        .transmitting (transmitting)
    );

endmodule

// ==== testbench/dhcp_top_tb.sv ====
`timescale 1ns/10ps

module dhcp_top_tb;

    logic                 clk;
    logic                 reset;
    dhcp_pkg::udp_rx_t    udp_in;
    logic                 udp_out_ready;
    dhcp_pkg::tx_result_e udp_out_result;
    dhcp_pkg::udp_tx_t    udp_out;
    dhcp_pkg::host_bus_t  host;
    dhcp_pkg::byte_t      host_rd_data;
    dhcp_pkg::mac_addr_t  mac_address;
    logic                 do_dhcp;
    dhcp_pkg::ip_addr_t   ip_address;
    logic                 ip_address_valid;

    int     cycle_count = 0;
    int     cycle_limit = 2000;    // Raised once the trace length is known
    integer seed;

    dhcp_top dhcp_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the trace did not finish", cycle_count);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s = %b, expected %b", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input dhcp_pkg::byte_t actual,
                              input dhcp_pkg::byte_t expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s = %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_ip(input dhcp_pkg::ip_addr_t actual, input dhcp_pkg::ip_addr_t expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: ip_address = %h, expected %h", $time, actual, expected);
            stop_run();
        end
    endtask

    // Only the fields a transmitted byte is judged by
    task automatic check_tx(input dhcp_pkg::udp_tx_t actual, input dhcp_pkg::udp_tx_t expected);
        string got_text;
        string want_text;
        if (actual.data !== expected.data || actual.last !== expected.last ||
            actual.length !== expected.length || actual.dst_ip !== expected.dst_ip ||
            actual.dst_port !== expected.dst_port) begin
            got_text  = $sformatf("%h/%b/%0d/%h/%0d", actual.data, actual.last,
                                  actual.length, actual.dst_ip, actual.dst_port);
            want_text = $sformatf("%h/%b/%0d/%h/%0d", expected.data, expected.last,
                                  expected.length, expected.dst_ip, expected.dst_port);
            $display("FAILED at time %0t: udp_out data/last/length/ip/port = %s, expected %s",
                     $time, got_text, want_text);
            stop_run();
        end
    endtask

    task automatic host_write(input dhcp_pkg::byte_t port, input dhcp_pkg::byte_t data);
        @(posedge clk);
        host <= '{1'b1, port, data};
        @(posedge clk);
        host <= '0;                                     // Strobe lasts one cycle
    endtask

    task automatic host_read(input dhcp_pkg::byte_t port, input dhcp_pkg::byte_t expected);
        @(posedge clk);
        host <= '{1'b0, port, 8'h00};
        @(posedge clk);                                 // Data registered here
        @(negedge clk);
        check_byte($sformatf("host_rd_data[%h]", port), host_rd_data, expected);
    endtask

    // Bytes come straight from the trace line
    task automatic send_packet(input int fd, input int first, input int fin, input int count);
        dhcp_pkg::udp_rx_t beat;
        int                b;
        int                r;
        for (int i = 0; i < count; i++) begin
            r          = $fscanf(fd, "%h", b);
            beat.start = (first != 0) && (i == 0);      // Start pulse rides on byte 0
            beat.data  = b[7:0];
            beat.valid = 1'b1;
            beat.last  = (fin != 0) && (i == count - 1);
            @(posedge clk);
            udp_in <= beat;
        end
        @(posedge clk);
        udp_in <= '0;
    endtask

    task automatic check_transmit(input int fd, input int delay, input int count);
        dhcp_pkg::udp_tx_t expected;
        int                b;
        int                r;
        int                got;
        int                rnd;
        got               = 0;
        expected          = '0;
        expected.length   = 9'(count);
        expected.dst_ip   = 32'hFFFF_FFFF;              // Broadcast to the server port
        expected.dst_port = 16'd67;
        @(negedge clk);
        while (!udp_out.start)
            @(negedge clk);
        repeat (delay) begin
            @(negedge clk);
            check_bit("udp_out.start", udp_out.start, 1'b1);   // Held while unanswered
        end
        @(posedge clk);
        udp_out_result <= dhcp_pkg::TX_RESULT_ACCEPTED;
        @(posedge clk);
        udp_out_result <= dhcp_pkg::TX_RESULT_NONE;
        @(negedge clk);
        check_bit("udp_out.start", udp_out.start, 1'b0);
        while (got < count) begin
            @(posedge clk);
            rnd = $random(seed);
            udp_out_ready <= rnd[0];                    // Random back-pressure
            @(negedge clk);
            if (udp_out.valid && udp_out_ready) begin
                r             = $fscanf(fd, "%h", b);
                expected.data = b[7:0];
                expected.last = (got == count - 1);
                check_tx(udp_out, expected);
                got++;
            end
        end
        // Ready stays high so a byte past the final one would show up
        repeat (2) begin
            @(posedge clk);
            udp_out_ready <= 1'b1;
            @(negedge clk);
            check_bit("udp_out.valid", udp_out.valid, 1'b0);
            check_bit("udp_out.last", udp_out.last, 1'b0);
        end
        @(posedge clk);
        udp_out_ready <= 1'b0;
    endtask

    initial begin
        int                  fd;
        int                  r;
        int                  lines;
        int                  first;
        int                  fin;
        int                  count;
        logic [7:0]          cmd;
        dhcp_pkg::byte_t     port;
        dhcp_pkg::byte_t     data;
        dhcp_pkg::mac_addr_t mac;
        dhcp_pkg::ip_addr_t  ip;
        logic                ip_valid;
        logic [8*200-1:0]    text;
        seed           = 84007;
        lines          = 0;
        reset          <= 1'b1;
        udp_in         <= '0;
        udp_out_ready  <= 1'b0;
        udp_out_result <= dhcp_pkg::TX_RESULT_NONE;
        host           <= '0;
        mac_address    <= '0;
        do_dhcp        <= 1'b0;
        fd = $fopen("testbench/dhcp_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file testbench/dhcp_trace.txt");
            stop_run();
        end
        while (!$feof(fd)) begin
            r = $fgets(text, fd);
            lines++;
        end
        $fclose(fd);
        cycle_limit = 2000 + 1200 * lines;
        fd = $fopen("testbench/dhcp_trace.txt", "r");
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("udp_out.start", udp_out.start, 1'b0);
        check_bit("udp_out.valid", udp_out.valid, 1'b0);
        check_bit("udp_out.last", udp_out.last, 1'b0);
        check_bit("ip_address_valid", ip_address_valid, 1'b0);
        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": r = $fgets(text, fd);              // Comment line
                "W": begin
                    r = $fscanf(fd, "%h %h", port, data);
                    host_write(port, data);
                end
                "R": begin
                    r = $fscanf(fd, "%h %h", port, data);
                    host_read(port, data);
                end
                "P": begin
                    r = $fscanf(fd, "%d %d %d", first, fin, count);
                    send_packet(fd, first, fin, count);
                end
                "T": begin
                    r = $fscanf(fd, "%d %d", first, count);   // Result delay and byte count
                    check_transmit(fd, first, count);
                end
                "M": begin
                    r = $fscanf(fd, "%h", mac);
                    @(posedge clk);
                    mac_address <= mac;
                end
                "D": begin
                    @(posedge clk);
                    do_dhcp <= 1'b1;
                    @(posedge clk);
                    do_dhcp <= 1'b0;
                end
                "I": begin
                    r = $fscanf(fd, "%h %h", ip, ip_valid);
                    @(negedge clk);
                    check_ip(ip_address, ip);
                    check_bit("ip_address_valid", ip_address_valid, ip_valid);
                end
                default: begin
                    $display("Unknown command '%c' in the trace file", cmd);
                    stop_run();
                end
            endcase
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== testbench/dhcp_trace.txt ====
# W port data, R port expected, P start last count bytes, T delay count bytes
# M mac, D pulse, I ip valid; start, last, count and delay decimal, all else hex
M 02a0c9123456
R 00 00
R 08 02
R 0d 56
W 01 01
W 85 5a
W 01 03
W ff c3
R ff c3
W 01 01
R 85 5a
R 0e 00
W 01 00
W 00 01
R 00 01
P 1 0 8 63 82 53 63 a1 b2 c3 d4
R 00 02
P 0 0 1 35
R 00 06
P 0 1 1 ee
R 13 d4
R 10 a1
P 1 1 4 11 22 33 44
R 80 63
R 11 b2
D
R 00 40
W 02 09
W 00 10
T 3 10 63 82 53 63 a1 b2 c3 d4 35 ee
W 02 00
W 00 10
T 0 1 63
W 06 a8
W 07 c0
I c0a80000 0
W 00 80
I c0a80000 1
R 00 c0

// ==== verilog.f ====
verilog/dhcp_pkg.sv
verilog/udp_rx_capture.sv
verilog/packet_buffer.sv
verilog/host_regs.sv
verilog/udp_tx_stream.sv
verilog/dhcp_top.sv
testbench/dhcp_top_tb.sv

// ==== Makefile ====
SOURCES = $(shell cat verilog.f)

.PHONY: all run clean

all: run

obj_dir/Vdhcp_top_tb: verilog.f $(SOURCES)
	verilator --binary --timing --assert -f verilog.f --top-module dhcp_top_tb -o Vdhcp_top_tb

sim.log: obj_dir/Vdhcp_top_tb testbench/dhcp_trace.txt
	./obj_dir/Vdhcp_top_tb | tee sim.log

run: sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
